//--- include/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// queue geometry
`define IQ_DEPTH    4
`define IQ_DISP_W   4   // dispatch slots per cycle
`define IQ_WAKE_N   4   // alu0, alu1, agu, bru

// instruction field widths
`define IQ_TAG_W    7   // physical register tag
`define IQ_ROB_W    6
`define IQ_OP_W     3

`endif

//--- hdl/iq_types_pkg.sv
`include "iq_macros.svh"

package iq_types_pkg;

    // physical register tag of a source, destination or broadcast
    typedef logic [`IQ_TAG_W-1:0] preg_tag_t;

    typedef logic [`IQ_ROB_W-1:0] rob_id_t;

    typedef logic [`IQ_OP_W-1:0]  alu_op_t;    // alu function code

endpackage

//--- hdl/iq_ctrl_pkg.sv
`include "iq_macros.svh"

package iq_ctrl_pkg;

    typedef logic [$clog2(`IQ_DEPTH)-1:0] entry_idx_t;

    // where an entry takes its next state from
    typedef enum logic [2:0] {
        SRC_HOLD  = 3'd0,
        SRC_SHIFT = 3'd1,   // entry above moves down
        SRC_SLOT0 = 3'd2,
        SRC_SLOT1 = 3'd3,
        SRC_SLOT2 = 3'd4,
        SRC_SLOT3 = 3'd5,
        SRC_CLEAR = 3'd6
    } entry_src_t;

endpackage

//--- hdl/iq_ctrl.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_ctrl
    import iq_ctrl_pkg::*;
(
    input  logic [`IQ_DEPTH-1:0]        entry_vld,
    input  logic [`IQ_DEPTH-1:0]        entry_ready,
    input  logic [`IQ_DISP_W-1:0]       disp_en,
    input  logic                        stall,
    output logic [`IQ_DEPTH-1:0]        grant,
    output entry_src_t [`IQ_DEPTH-1:0]  entry_sel,
    output logic                        pause
);

    localparam int CNT_W = $clog2(`IQ_DEPTH + 1) + 1;

    logic [`IQ_DEPTH-1:0]   req;
    logic                   has_grant;
    logic                   accept;
    entry_idx_t             grant_idx;
    logic [CNT_W-1:0]       n_vld;
    logic [CNT_W-1:0]       n_keep;
    logic [CNT_W-1:0]       n_need;
    logic [CNT_W-1:0]       room;
    logic [CNT_W-1:0]       slot_pos [`IQ_DISP_W];

    assign req       = entry_vld & entry_ready;
    assign grant     = stall ? '0 : req & (~req + 1'b1);   // lowest index is oldest
    assign has_grant = |grant;

    always_comb begin
        n_vld     = '0;
        grant_idx = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            n_vld = n_vld + CNT_W'(entry_vld[i]);
            if (grant[i])
                grant_idx = entry_idx_t'(i);
        end
    end

    // valid entries are packed from index 0, so survivors end at n_keep
    assign n_keep = n_vld - CNT_W'(has_grant);
    assign room   = CNT_W'(`IQ_DEPTH) - n_keep;

    // target position of every enabled slot with gaps in disp_en squeezed out
    always_comb begin
        n_need = '0;
        for (int s = 0; s < `IQ_DISP_W; s++) begin
            slot_pos[s] = n_keep + n_need;
            n_need      = n_need + CNT_W'(disp_en[s]);
        end
    end

    assign pause  = n_need > room;
    assign accept = ~pause & ~stall;   // all or nothing

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (has_grant && entry_idx_t'(i) >= grant_idx)
                entry_sel[i] = (i == `IQ_DEPTH - 1) ? SRC_CLEAR : SRC_SHIFT;
            else
                entry_sel[i] = SRC_HOLD;

            // a load wins over shift or clear at the same position
            for (int s = 0; s < `IQ_DISP_W; s++) begin
                if (accept && disp_en[s] && slot_pos[s] == CNT_W'(i))
                    entry_sel[i] = entry_src_t'(SRC_SLOT0 + s);
            end
        end
    end

endmodule

//--- hdl/iq_wakeup.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_wakeup
    import iq_types_pkg::*;
(
    input  preg_tag_t [`IQ_DEPTH-1:0]   entry_src1,
    input  preg_tag_t [`IQ_DEPTH-1:0]   entry_src2,
    input  preg_tag_t [`IQ_WAKE_N-1:0]  wake_tag,
    output logic [`IQ_DEPTH-1:0]        src1_hit,
    output logic [`IQ_DEPTH-1:0]        src2_hit
);

    // hits stay per stored position so a shifting entry can use its own
    always_comb begin
        src1_hit = '0;
        src2_hit = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            for (int w = 0; w < `IQ_WAKE_N; w++) begin
                if (entry_src1[i] == wake_tag[w])
                    src1_hit[i] = 1'b1;
                if (entry_src2[i] == wake_tag[w])
                    src2_hit[i] = 1'b1;
            end
        end
    end

endmodule

//--- hdl/iq_entry_array.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_entry_array
    import iq_types_pkg::*;
    import iq_ctrl_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush,
    input  entry_src_t [`IQ_DEPTH-1:0]      entry_sel,
    input  logic [`IQ_DEPTH-1:0]            grant,
    input  logic [`IQ_DISP_W-1:0]           disp_src1_rdy,
    input  logic [`IQ_DISP_W-1:0]           disp_src2_rdy,
    input  preg_tag_t [`IQ_DISP_W-1:0]      disp_dest,
    input  preg_tag_t [`IQ_DISP_W-1:0]      disp_src1,
    input  preg_tag_t [`IQ_DISP_W-1:0]      disp_src2,
    input  alu_op_t [`IQ_DISP_W-1:0]        disp_op,
    input  rob_id_t [`IQ_DISP_W-1:0]        disp_rob_id,
    input  logic [`IQ_DEPTH-1:0]            src1_hit,
    input  logic [`IQ_DEPTH-1:0]            src2_hit,
    output logic [`IQ_DEPTH-1:0]            entry_vld,
    output logic [`IQ_DEPTH-1:0]            entry_ready,
    output preg_tag_t [`IQ_DEPTH-1:0]       entry_src1,
    output preg_tag_t [`IQ_DEPTH-1:0]       entry_src2,
    output preg_tag_t [`IQ_DEPTH-1:0]       entry_dest,
    output alu_op_t [`IQ_DEPTH-1:0]         entry_op,
    output rob_id_t [`IQ_DEPTH-1:0]         entry_rob_id
);

    localparam int SLOT_W = $clog2(`IQ_DISP_W);

    logic [`IQ_DEPTH-1:0]   rdy1_q;
    logic [`IQ_DEPTH-1:0]   rdy2_q;
    logic [`IQ_DEPTH-1:0]   vld_d;
    logic [`IQ_DEPTH-1:0]   rdy1_d;
    logic [`IQ_DEPTH-1:0]   rdy2_d;
    logic [`IQ_DEPTH-1:0]   load_en;
    logic [SLOT_W-1:0]      load_slot [`IQ_DEPTH];

    // the top entry has nothing above it
    function automatic int above(input int i);
        return (i < `IQ_DEPTH - 1) ? i + 1 : i;
    endfunction

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            load_slot[i] = SLOT_W'(int'(entry_sel[i]) - int'(SRC_SLOT0));
            load_en[i]   = 1'b0;
            vld_d[i]     = entry_vld[i] & ~grant[i];   // granted entry leaves
            rdy1_d[i]    = rdy1_q[i] | src1_hit[i];
            rdy2_d[i]    = rdy2_q[i] | src2_hit[i];
            case (entry_sel[i])
                SRC_SHIFT: begin
                    vld_d[i]  = (i < `IQ_DEPTH - 1) && entry_vld[above(i)];
                    rdy1_d[i] = rdy1_q[above(i)] | src1_hit[above(i)];
                    rdy2_d[i] = rdy2_q[above(i)] | src2_hit[above(i)];
                end
                SRC_SLOT0, SRC_SLOT1, SRC_SLOT2, SRC_SLOT3: begin
                    load_en[i] = 1'b1;
                    vld_d[i]   = 1'b1;
                    rdy1_d[i]  = disp_src1_rdy[load_slot[i]];
                    rdy2_d[i]  = disp_src2_rdy[load_slot[i]];
                end
                SRC_CLEAR: begin
                    vld_d[i]  = 1'b0;
                    rdy1_d[i] = 1'b0;
                    rdy2_d[i] = 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
            rdy1_q    <= '0;
            rdy2_q    <= '0;
        end else if (flush) begin
            entry_vld <= '0;
            rdy1_q    <= '0;
            rdy2_q    <= '0;
        end else begin
            entry_vld <= vld_d;
            rdy1_q    <= rdy1_d;
            rdy2_q    <= rdy2_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (load_en[i]) begin
                entry_src1[i]   <= disp_src1[load_slot[i]];
                entry_src2[i]   <= disp_src2[load_slot[i]];
                entry_dest[i]   <= disp_dest[load_slot[i]];
                entry_op[i]     <= disp_op[load_slot[i]];
                entry_rob_id[i] <= disp_rob_id[load_slot[i]];
            end else if (entry_sel[i] == SRC_SHIFT) begin
                entry_src1[i]   <= entry_src1[above(i)];
                entry_src2[i]   <= entry_src2[above(i)];
                entry_dest[i]   <= entry_dest[above(i)];
                entry_op[i]     <= entry_op[above(i)];
                entry_rob_id[i] <= entry_rob_id[above(i)];
            end
        end
    end

    assign entry_ready = rdy1_q & rdy2_q;

endmodule

//--- hdl/iq_issue_reg.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_issue_reg
    import iq_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic [`IQ_DEPTH-1:0]        grant,
    input  preg_tag_t [`IQ_DEPTH-1:0]   entry_dest,
    input  preg_tag_t [`IQ_DEPTH-1:0]   entry_src1,
    input  preg_tag_t [`IQ_DEPTH-1:0]   entry_src2,
    input  alu_op_t [`IQ_DEPTH-1:0]     entry_op,
    input  rob_id_t [`IQ_DEPTH-1:0]     entry_rob_id,
    output logic                        issue_vld,
    output alu_op_t                     issue_op,
    output preg_tag_t                   issue_dest,
    output preg_tag_t                   issue_src1,
    output preg_tag_t                   issue_src2,
    output rob_id_t                     issue_rob_id
);

    preg_tag_t  sel_dest;
    preg_tag_t  sel_src1;
    preg_tag_t  sel_src2;
    alu_op_t    sel_op;
    rob_id_t    sel_rob_id;

    // and-or mux over a one-hot grant
    always_comb begin
        sel_dest   = '0;
        sel_src1   = '0;
        sel_src2   = '0;
        sel_op     = '0;
        sel_rob_id = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            sel_dest   = sel_dest   | (entry_dest[i]   & {`IQ_TAG_W{grant[i]}});
            sel_src1   = sel_src1   | (entry_src1[i]   & {`IQ_TAG_W{grant[i]}});
            sel_src2   = sel_src2   | (entry_src2[i]   & {`IQ_TAG_W{grant[i]}});
            sel_op     = sel_op     | (entry_op[i]     & {`IQ_OP_W{grant[i]}});
            sel_rob_id = sel_rob_id | (entry_rob_id[i] & {`IQ_ROB_W{grant[i]}});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            issue_vld <= 1'b0;
        else if (flush)
            issue_vld <= 1'b0;
        else
            issue_vld <= |grant;   // grant is already zero under stall
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            issue_dest   <= sel_dest;
            issue_src1   <= sel_src1;
            issue_src2   <= sel_src2;
            issue_op     <= sel_op;
            issue_rob_id <= sel_rob_id;
        end
    end

endmodule

//--- hdl/iq_top.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_top
    import iq_types_pkg::*;
    import iq_ctrl_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        stall,
    input  logic [`IQ_DISP_W-1:0]       disp_en,
    input  logic [`IQ_DISP_W-1:0]       disp_src1_rdy,
    input  logic [`IQ_DISP_W-1:0]       disp_src2_rdy,
    input  preg_tag_t [`IQ_DISP_W-1:0]  disp_dest,
    input  preg_tag_t [`IQ_DISP_W-1:0]  disp_src1,
    input  preg_tag_t [`IQ_DISP_W-1:0]  disp_src2,
    input  alu_op_t [`IQ_DISP_W-1:0]    disp_op,
    input  rob_id_t [`IQ_DISP_W-1:0]    disp_rob_id,
    input  preg_tag_t [`IQ_WAKE_N-1:0]  wake_tag,
    output logic                        pause,
    output logic                        issue_vld,
    output alu_op_t                     issue_op,
    output preg_tag_t                   issue_dest,
    output preg_tag_t                   issue_src1,
    output preg_tag_t                   issue_src2,
    output rob_id_t                     issue_rob_id
);

    logic [`IQ_DEPTH-1:0]       entry_vld;
    logic [`IQ_DEPTH-1:0]       entry_ready;
    logic [`IQ_DEPTH-1:0]       grant;
    entry_src_t [`IQ_DEPTH-1:0] entry_sel;
    logic [`IQ_DEPTH-1:0]       src1_hit;
    logic [`IQ_DEPTH-1:0]       src2_hit;
    preg_tag_t [`IQ_DEPTH-1:0]  entry_src1;
    preg_tag_t [`IQ_DEPTH-1:0]  entry_src2;
    preg_tag_t [`IQ_DEPTH-1:0]  entry_dest;
    alu_op_t [`IQ_DEPTH-1:0]    entry_op;
    rob_id_t [`IQ_DEPTH-1:0]    entry_rob_id;

    iq_ctrl u_ctrl (
        .entry_vld   (entry_vld),
        .entry_ready (entry_ready),
        .disp_en     (disp_en),
        .stall       (stall),
        .grant       (grant),
        .entry_sel   (entry_sel),
        .pause       (pause)
    );

    iq_wakeup u_wakeup (
        .entry_src1 (entry_src1),
        .entry_src2 (entry_src2),
        .wake_tag   (wake_tag),
        .src1_hit   (src1_hit),
        .src2_hit   (src2_hit)
    );

    iq_entry_array u_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .entry_sel     (entry_sel),
        .grant         (grant),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2_rdy (disp_src2_rdy),
        .disp_dest     (disp_dest),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .disp_op       (disp_op),
        .disp_rob_id   (disp_rob_id),
        .src1_hit      (src1_hit),
        .src2_hit      (src2_hit),
        .entry_vld     (entry_vld),
        .entry_ready   (entry_ready),
        .entry_src1    (entry_src1),
        .entry_src2    (entry_src2),
        .entry_dest    (entry_dest),
        .entry_op      (entry_op),
        .entry_rob_id  (entry_rob_id)
    );

    iq_issue_reg u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .grant        (grant),
        .entry_dest   (entry_dest),
        .entry_src1   (entry_src1),
        .entry_src2   (entry_src2),
        .entry_op     (entry_op),
        .entry_rob_id (entry_rob_id),
        .issue_vld    (issue_vld),
        .issue_op     (issue_op),
        .issue_dest   (issue_dest),
        .issue_src1   (issue_src1),
        .issue_src2   (issue_src2),
        .issue_rob_id (issue_rob_id)
    );

endmodule

//--- testbench/iq_assert.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module iq_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush,
    input logic                 stall,
    input logic                 pause,
    input logic                 issue_vld,
    input logic [`IQ_DEPTH-1:0] entry_vld
);

    int unsigned fail_cnt = 0;

    // an empty queue takes any group
    pause_empty: assert property (@(posedge clk) disable iff (!rst_n)
        entry_vld == '0 |-> !pause)
    else begin
        fail_cnt++;
        $error("pause high with the queue empty");
    end

    no_issue_after_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (flush || stall) |=> !issue_vld)
    else begin
        fail_cnt++;
        $error("issue_vld high the cycle after flush or stall");
    end

    reset_idle: assert property (@(posedge clk) !rst_n |=> !issue_vld)
    else begin
        fail_cnt++;
        $error("issue_vld high after reset");
    end

endmodule

bind iq_top iq_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .stall     (stall),
    .pause     (pause),
    .issue_vld (issue_vld),
    .entry_vld (entry_vld)
);

//--- testbench/tb_iq.sv
`timescale 1ns/1ps
`include "iq_macros.svh"

module tb_iq
    import iq_types_pkg::*;
();

    localparam int PERIOD = 4;
    localparam int BUDGET = 5 + 1 + 6 + 7 + 9 + 6 + 7 + 20;   // reset, six tests, margin
    localparam preg_tag_t IDLE_TAG = 7'd127;                   // no source uses it

    logic                       clk;
    logic                       rst_n;
    logic                       flush;
    logic                       stall;
    logic [`IQ_DISP_W-1:0]      disp_en;
    logic [`IQ_DISP_W-1:0]      disp_src1_rdy;
    logic [`IQ_DISP_W-1:0]      disp_src2_rdy;
    preg_tag_t [`IQ_DISP_W-1:0] disp_dest;
    preg_tag_t [`IQ_DISP_W-1:0] disp_src1;
    preg_tag_t [`IQ_DISP_W-1:0] disp_src2;
    alu_op_t [`IQ_DISP_W-1:0]   disp_op;
    rob_id_t [`IQ_DISP_W-1:0]   disp_rob_id;
    preg_tag_t [`IQ_WAKE_N-1:0] wake_tag;
    logic                       pause;
    logic                       issue_vld;
    alu_op_t                    issue_op;
    preg_tag_t                  issue_dest;
    preg_tag_t                  issue_src1;
    preg_tag_t                  issue_src2;
    rob_id_t                    issue_rob_id;

    // expected fields, indexed by rob id
    alu_op_t     ins_op [32];
    preg_tag_t   ins_dest [32];
    preg_tag_t   ins_src1 [32];
    preg_tag_t   ins_src2 [32];
    logic [31:0] seed = 32'h90b1_8a79;
    int          errors = 0;
    int          tests = 0;
    int          test_errs = 0;

    iq_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(BUDGET * PERIOD);
        $display("timeout, the tests did not complete within %0d cycles", BUDGET);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic tick_idle();
        tick();
        check_val("issue_vld", issue_vld, 0);
    endtask

    task automatic tick_issue(input int idx);
        tick();
        check_val("issue_vld", issue_vld, 1);
        check_val("issue_rob_id", issue_rob_id, idx);
        check_val("issue_op", issue_op, ins_op[idx]);
        check_val("issue_dest", issue_dest, ins_dest[idx]);
        check_val("issue_src1", issue_src1, ins_src1[idx]);
        check_val("issue_src2", issue_src2, ins_src2[idx]);
    endtask

    // a nonzero tag marks that source as waiting on it
    task automatic put(input int s, input int idx, input preg_tag_t t1, input preg_tag_t t2);
        ins_op[idx]      = alu_op_t'(next_rand() >> 16);
        ins_dest[idx]    = preg_tag_t'(next_rand() % 100);
        ins_src1[idx]    = (t1 != 0) ? t1 : preg_tag_t'(next_rand() % 100);
        ins_src2[idx]    = (t2 != 0) ? t2 : preg_tag_t'(next_rand() % 100);
        disp_en[s]       = 1'b1;
        disp_src1_rdy[s] = (t1 == 0);
        disp_src2_rdy[s] = (t2 == 0);
        disp_op[s]       = ins_op[idx];
        disp_dest[s]     = ins_dest[idx];
        disp_src1[s]     = ins_src1[idx];
        disp_src2[s]     = ins_src2[idx];
        disp_rob_id[s]   = rob_id_t'(idx);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, test_errs);
        errors    += test_errs;
        tests++;
        test_errs = 0;
    endtask

    task automatic test_reset();
        check_val("issue_vld", issue_vld, 0);
        stall   = 1'b1;                 // held off so nothing is written
        disp_en = '1;
        #1;
        check_val("pause", pause, 0);   // a full group fits an empty queue
        tick();
        stall   = 1'b0;
        disp_en = '0;
        finish_test("reset");
    endtask

    task automatic test_full_group();
        for (int s = 0; s < 4; s++)
            put(s, s, 0, 0);
        tick();
        disp_en = '0;
        check_val("issue_vld", issue_vld, 0);
        for (int i = 0; i < 4; i++)
            tick_issue(i);
        tick_idle();
        finish_test("full group");
    endtask

    task automatic test_overtake();
        put(0, 4, 7'd100, 7'd101);
        put(1, 5, 0, 0);
        tick();
        disp_en = '0;
        tick_issue(5);
        wake_tag[0] = 7'd100;
        tick_idle();
        wake_tag[0] = IDLE_TAG;
        tick_idle();                    // src2 still missing
        wake_tag[1] = 7'd101;
        tick_idle();
        wake_tag[1] = IDLE_TAG;
        tick_issue(4);
        tick_idle();
        finish_test("overtake");
    endtask

    task automatic test_pause();
        for (int s = 0; s < 4; s++)
            put(s, 6 + s, preg_tag_t'(102 + s), 0);
        tick();
        disp_en = '0;
        put(0, 10, 0, 0);               // would issue if it got in
        #1;
        check_val("pause", pause, 1);
        tick();
        check_val("pause", pause, 1);
        disp_en  = '0;
        wake_tag = {7'd105, 7'd104, 7'd103, 7'd102};
        tick_idle();
        wake_tag = {4{IDLE_TAG}};
        for (int i = 6; i < 10; i++)
            tick_issue(i);
        tick_idle();
        tick_idle();
        finish_test("pause");
    endtask

    task automatic test_stall();
        put(0, 11, 0, 0);
        put(1, 12, 0, 0);
        tick();
        disp_en = '0;
        stall   = 1'b1;
        put(2, 13, 0, 0);               // offered while stalled
        tick_idle();
        tick_idle();
        stall   = 1'b0;
        disp_en = '0;
        tick_issue(11);
        tick_issue(12);
        tick_idle();
        finish_test("stall");
    endtask

    task automatic test_flush();
        put(0, 14, 0, 0);
        put(1, 15, 0, 0);
        for (int s = 2; s < 4; s++)
            put(s, 14 + s, preg_tag_t'(109 + s), 0);
        tick();
        disp_en = '0;
        tick_issue(14);
        flush = 1'b1;                   // rob 15 is granted in this cycle
        tick_idle();
        flush    = 1'b0;
        wake_tag = {7'd112, 7'd111, IDLE_TAG, IDLE_TAG};
        tick_idle();
        wake_tag = {4{IDLE_TAG}};
        repeat (3)
            tick_idle();
        finish_test("flush");
    endtask

    initial begin
        rst_n         = 1'b0;
        flush         = 1'b0;
        stall         = 1'b0;
        disp_en       = '0;
        disp_src1_rdy = '0;
        disp_src2_rdy = '0;
        disp_dest     = '0;
        disp_src1     = '0;
        disp_src2     = '0;
        disp_op       = '0;
        disp_rob_id   = '0;
        wake_tag      = {4{IDLE_TAG}};
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_full_group();
        test_overtake();
        test_pause();
        test_stall();
        test_flush();
        errors += uut.u_assert.fail_cnt;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
hdl/iq_types_pkg.sv
hdl/iq_ctrl_pkg.sv
hdl/iq_ctrl.sv
hdl/iq_wakeup.sv
hdl/iq_entry_array.sv
hdl/iq_issue_reg.sv
hdl/iq_top.sv
testbench/iq_assert.sv
testbench/tb_iq.sv

//--- Bender.yml
package:
  name: iq

export_include_dirs:
  - include

sources:
  - hdl/iq_types_pkg.sv
  - hdl/iq_ctrl_pkg.sv
  - hdl/iq_ctrl.sv
  - hdl/iq_wakeup.sv
  - hdl/iq_entry_array.sv
  - hdl/iq_issue_reg.sv
  - hdl/iq_top.sv
  - target: test
    files:
      - testbench/iq_assert.sv
      - testbench/tb_iq.sv
